// File: source/rtf_pkg.sv
// shared definitions for the instruction alignment stage
//   opcode byte values of the reduced opcode table
//   functional unit class codes carried in the predecode byte
//   fetch word, queue and instruction sizes in bytes
`default_nettype none

package rtf_pkg;

  // ==========================================================================
  // opcode values
  // ==========================================================================

  // alu group
  localparam logic [7:0] op_add   = 8'h04;
  localparam logic [7:0] op_sub   = 8'h05;
  localparam logic [7:0] op_and   = 8'h08;
  localparam logic [7:0] op_or    = 8'h09;
  localparam logic [7:0] op_csr   = 8'h0f;
  localparam logic [7:0] op_perm  = 8'h13;
  localparam logic [7:0] op_add5  = 8'h2a;
  localparam logic [7:0] op_or5   = 8'h2b;
  localparam logic [7:0] op_add2r = 8'h2c;
  localparam logic [7:0] op_or2r  = 8'h2d;
  localparam logic [7:0] op_addui = 8'h30;
  localparam logic [7:0] op_orui  = 8'h31;
  // flow control group
  localparam logic [7:0] op_blr   = 8'h40;
  localparam logic [7:0] op_jmp   = 8'h41;
  localparam logic [7:0] op_jsr   = 8'h42;
  localparam logic [7:0] op_beq   = 8'h48;
  localparam logic [7:0] op_bne   = 8'h49;
  localparam logic [7:0] op_blt   = 8'h4a;
  localparam logic [7:0] op_bge   = 8'h4b;
  // system group
  localparam logic [7:0] op_brk   = 8'h00;
  localparam logic [7:0] op_nop   = 8'hea;
  // memory group, the short forms end in s
  localparam logic [7:0] op_ldb   = 8'h80;
  localparam logic [7:0] op_ldo   = 8'h84;
  localparam logic [7:0] op_ldos  = 8'h94;
  localparam logic [7:0] op_stb   = 8'ha0;
  localparam logic [7:0] op_sto   = 8'ha4;
  localparam logic [7:0] op_stos  = 8'hb4;
  // post-op and float groups
  localparam logic [7:0] op_pma   = 8'hd0;
  localparam logic [7:0] op_pms   = 8'hd1;
  localparam logic [7:0] op_fma   = 8'he0;
  localparam logic [7:0] op_fms   = 8'he1;

  // ==========================================================================
  // unit classes, upper nibble of the predecode byte
  // ==========================================================================
  localparam logic [3:0] unit_alu     = 4'd0;
  localparam logic [3:0] unit_branch  = 4'd1;
  localparam logic [3:0] unit_system  = 4'd3;
  localparam logic [3:0] unit_memory  = 4'd4;
  localparam logic [3:0] unit_post    = 4'd5;
  localparam logic [3:0] unit_float   = 4'd6;
  localparam logic [3:0] unit_default = 4'd7;

  // sizes of the fetch path
  localparam int fetch_bytes     = 4;
  localparam int queue_bytes     = 16;
  localparam int max_instr_bytes = 8;
  // count must hold 0 to 16 and the pointers index 16 bytes
  localparam int count_width     = 5;
  localparam int ptr_width       = 4;

endpackage

`default_nettype wire

// File: source/rtf_predecoder.sv
// opcode predecoder
//   maps an opcode byte to {unit class, length in bytes}
//   bytes outside the table get class 7 and length 4
`timescale 1ns/1ps
`default_nettype none

module rtf_predecoder
  import rtf_pkg::*;
(
  input  logic [7:0] opcode,
  output logic [7:0] code
);

  // the lower nibble is the instruction length, counting the opcode byte,
  // and the upper nibble the unit that will execute it
  always_comb begin
    case (opcode)
      // plain register forms carry three register fields
      op_add:   code = {unit_alu, 4'd4};
      op_sub:   code = {unit_alu, 4'd4};
      op_and:   code = {unit_alu, 4'd4};
      op_or:    code = {unit_alu, 4'd4};
      // csr needs an extra byte for the register number
      op_csr:   code = {unit_alu, 4'd5};
      op_perm:  code = {unit_alu, 4'd6};
      // short immediate and two-register forms
      op_add5:  code = {unit_alu, 4'd3};
      op_or5:   code = {unit_alu, 4'd3};
      op_add2r: code = {unit_alu, 4'd3};
      op_or2r:  code = {unit_alu, 4'd3};
      // upper immediates take a full 48 bit constant
      op_addui: code = {unit_alu, 4'd8};
      op_orui:  code = {unit_alu, 4'd8};

      op_blr:   code = {unit_branch, 4'd4};
      op_jmp:   code = {unit_branch, 4'd5};
      op_jsr:   code = {unit_branch, 4'd5};
      // conditional branches have a short displacement
      op_beq:   code = {unit_branch, 4'd3};
      op_bne:   code = {unit_branch, 4'd3};
      op_blt:   code = {unit_branch, 4'd3};
      op_bge:   code = {unit_branch, 4'd3};

      op_brk:   code = {unit_system, 4'd2};
      op_nop:   code = {unit_system, 4'd1};

      op_ldb:   code = {unit_memory, 4'd4};
      op_ldo:   code = {unit_memory, 4'd4};
      op_stb:   code = {unit_memory, 4'd4};
      op_sto:   code = {unit_memory, 4'd4};
      // short loads and stores drop the upper displacement byte
      op_ldos:  code = {unit_memory, 4'd3};
      op_stos:  code = {unit_memory, 4'd3};

      op_pma:   code = {unit_post, 4'd4};
      op_pms:   code = {unit_post, 4'd4};
      op_fma:   code = {unit_float, 4'd4};
      op_fms:   code = {unit_float, 4'd4};

      // anything unknown is sized like a full register op so the
      // stream keeps moving and decode raises the fault later
      default:  code = {unit_default, 4'd4};
    endcase
  end

endmodule

`default_nettype wire

// File: source/rtf_fetch_queue.sv
// byte queue between fetch and alignment
//   circular array of 16 bytes with read and write pointers
//   pushes one 4 byte fetch word, pops a variable number of bytes
//   presents the first 8 bytes at the read pointer for alignment
`timescale 1ns/1ps
`default_nettype none

module rtf_fetch_queue
  import rtf_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         push,
  input  logic [8*fetch_bytes-1:0]     push_data,
  input  logic                         pop,
  input  logic [3:0]                   pop_len,
  output logic                         room,
  output logic [count_width-1:0]       count,
  output logic [8*max_instr_bytes-1:0] head_bytes
);

  logic [7:0]             mem [queue_bytes];
  logic [ptr_width-1:0]   rd_ptr;
  logic [ptr_width-1:0]   wr_ptr;
  // byte counts added and removed at the next edge
  logic [count_width-1:0] push_n;
  logic [count_width-1:0] pop_n;

  assign push_n = push ? count_width'(fetch_bytes) : '0;
  assign pop_n  = pop ? count_width'(pop_len) : '0;

  // ==========================================================================
  // storage
  // ==========================================================================

  // the fetch word goes in lowest byte first, so byte 0 of the word
  // lands at the write pointer and the others follow it
  always_ff @(posedge clk) begin
    if (push) begin
      for (int i = 0; i < fetch_bytes; i++) begin
        mem[wr_ptr + ptr_width'(i)] <= push_data[8*i +: 8];
      end
    end
  end

  // the pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + ptr_width'(fetch_bytes);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + ptr_width'(pop_len);
      end
      // push and pop may land on the same edge
      count <= count + push_n - pop_n;
    end
  end

  // ==========================================================================
  // head window and fetch room
  // ==========================================================================

  // bytes past count are stale, the aligner only uses them once count
  // covers the instruction length
  always_comb begin
    for (int i = 0; i < max_instr_bytes; i++) begin
      head_bytes[8*i +: 8] = mem[rd_ptr + ptr_width'(i)];
    end
  end

  // room for one more whole word
  assign room = (count <= count_width'(queue_bytes - fetch_bytes));

endmodule

`default_nettype wire

// File: source/rtf_aligner.sv
// instruction aligner
//   predecodes the byte at the head of the queue
//   waits until the queue holds the whole instruction
//   registers it left aligned and zero filled, with length and unit,
//   and pops its bytes on the same edge
`timescale 1ns/1ps
`default_nettype none

module rtf_aligner
  import rtf_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic [count_width-1:0]       count,
  input  logic [8*max_instr_bytes-1:0] head_bytes,
  input  logic                         decode_stall,
  output logic                         pop,
  output logic [3:0]                   pop_len,
  output logic                         instr_valid,
  output logic [8*max_instr_bytes-1:0] instr_data,
  output logic [3:0]                   instr_len,
  output logic [3:0]                   instr_unit
);

  logic [7:0]                   head_code;
  logic [3:0]                   head_len;
  logic [3:0]                   head_unit;
  logic                         complete;
  logic                         take;
  logic [8*max_instr_bytes-1:0] masked;

  // byte 0 of the head is always an opcode once the queue is not empty
  rtf_predecoder u_predecoder (
    .opcode (head_bytes[7:0]),
    .code   (head_code)
  );

  assign head_len  = head_code[3:0];
  assign head_unit = head_code[7:4];

  // ==========================================================================
  // issue decision
  // ==========================================================================

  // every length is at least one byte, so an empty queue never
  // looks complete even while the head is stale
  assign complete = (count >= count_width'(head_len));
  assign take     = complete && !decode_stall;

  // the pop acts on the same edge as the output register, so the next
  // instruction is at the head in the following cycle
  assign pop     = take;
  assign pop_len = head_len;

  // clear every byte past the instruction length, those belong to
  // the next instruction or are stale
  always_comb begin
    for (int i = 0; i < max_instr_bytes; i++) begin
      if (i < head_len) begin
        masked[8*i +: 8] = head_bytes[8*i +: 8];
      end else begin
        masked[8*i +: 8] = 8'h00;
      end
    end
  end

  // ==========================================================================
  // output register
  // ==========================================================================

  // one cycle pulse per instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= take;
    end
  end

  // payload holds its value between instructions
  always_ff @(posedge clk) begin
    if (take) begin
      instr_data <= masked;
      instr_len  <= head_len;
      instr_unit <= head_unit;
    end
  end

endmodule

`default_nettype wire

// File: source/rtf_ifetch_top.sv
// instruction alignment stage top
//   fetch queue fed by 32 bit fetch words
//   aligner with predecoder feeding the decode stage
`timescale 1ns/1ps
`default_nettype none

module rtf_ifetch_top
  import rtf_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         fetch_valid,
  input  logic [8*fetch_bytes-1:0]     fetch_data,
  output logic                         fetch_ready,
  input  logic                         decode_stall,
  output logic                         instr_valid,
  output logic [8*max_instr_bytes-1:0] instr_data,
  output logic [3:0]                   instr_len,
  output logic [3:0]                   instr_unit
);

  logic [count_width-1:0]       count;
  logic [8*max_instr_bytes-1:0] head_bytes;
  logic                         pop;
  logic [3:0]                   pop_len;

  // a word is taken only while the queue has room for it
  rtf_fetch_queue u_queue (
    .clk        (clk),
    .reset      (reset),
    .push       (fetch_valid & fetch_ready),
    .push_data  (fetch_data),
    .pop        (pop),
    .pop_len    (pop_len),
    .room       (fetch_ready),
    .count      (count),
    .head_bytes (head_bytes)
  );

  rtf_aligner u_aligner (
    .clk          (clk),
    .reset        (reset),
    .count        (count),
    .head_bytes   (head_bytes),
    .decode_stall (decode_stall),
    .pop          (pop),
    .pop_len      (pop_len),
    .instr_valid  (instr_valid),
    .instr_data   (instr_data),
    .instr_len    (instr_len),
    .instr_unit   (instr_unit)
  );

endmodule

`default_nettype wire

// File: test/rtf_ifetch_chk.sv
// bound checks on the alignment stage ports
//   quiet output in reset, length range, stall and fetch protocol
`timescale 1ns/1ps
`default_nettype none

module rtf_ifetch_chk (
  input logic       clk,
  input logic       reset,
  input logic       fetch_valid,
  input logic       fetch_ready,
  input logic       decode_stall,
  input logic       instr_valid,
  input logic [3:0] instr_len
);

  // failed assertions, read back by the testbench at the end of the run
  int failures = 0;

  // the output register clears on the first edge with reset high
  a_reset_quiet: assert property (@(posedge clk) reset |=> !instr_valid)
    else begin
      $error("instr_valid high while reset is applied");
      failures++;
    end

  a_len_range: assert property (@(posedge clk) disable iff (reset)
      instr_valid |-> (instr_len >= 4'd1 && instr_len <= 4'd8))
    else begin
      $error("instr_len outside 1 to 8");
      failures++;
    end

  // a stalled cycle never issues, so the next cycle shows no pulse
  a_stall_quiet: assert property (@(posedge clk) disable iff (reset)
      decode_stall |=> !instr_valid)
    else begin
      $error("instr_valid after a stalled cycle");
      failures++;
    end

  a_fetch_protocol: assert property (@(posedge clk) disable iff (reset)
      fetch_valid |-> fetch_ready)
    else begin
      $error("fetch_valid high without fetch_ready");
      failures++;
    end

endmodule

// attached to every instance of the stage top
bind rtf_ifetch_top rtf_ifetch_chk u_chk (
  .clk          (clk),
  .reset        (reset),
  .fetch_valid  (fetch_valid),
  .fetch_ready  (fetch_ready),
  .decode_stall (decode_stall),
  .instr_valid  (instr_valid),
  .instr_len    (instr_len)
);

`default_nettype wire

// File: test/rtf_ifetch_tb.sv
// testbench for the instruction alignment stage
//   random instruction stream from a galois lfsr with a fixed seed
//   reference model of opcode length and unit class
//   checks order, alignment, stall and back-pressure
`timescale 1ns/1ps
`default_nettype none

module rtf_ifetch_tb
  import rtf_pkg::*;
();

  localparam int reset_cycles  = 16;
  localparam int stream_instrs = 150;
  localparam int stall_instrs  = 40;
  localparam int stall_cycles  = 40;
  // forty cycles per instruction covers random stalls and the long hold
  localparam int limit_cycles  = 40 * (stream_instrs + stall_instrs) + reset_cycles;

  logic        clk = 1'b0;
  logic        reset;
  logic        fetch_valid;
  logic [31:0] fetch_data;
  logic        fetch_ready;
  logic        decode_stall;
  logic        instr_valid;
  logic [63:0] instr_data;
  logic [3:0]  instr_len;
  logic [3:0]  instr_unit;

  logic [31:0] lfsr_state = 32'h50ad;
  logic [7:0]  op_table [31];
  // expected instructions in order, data and {unit, length}
  logic [63:0] exp_data_q [$];
  logic [7:0]  exp_code_q [$];
  logic [31:0] word_q [$];
  logic [7:0]  exp_code;
  logic        stall_last = 1'b0;
  string       test_name = "reset";
  int          cycles = 0;
  int          errors = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  rtf_ifetch_top uut (
    .clk          (clk),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .fetch_data   (fetch_data),
    .fetch_ready  (fetch_ready),
    .decode_stall (decode_stall),
    .instr_valid  (instr_valid),
    .instr_data   (instr_data),
    .instr_len    (instr_len),
    .instr_unit   (instr_unit)
  );

  always #10 clk = ~clk;

  // ==========================================================================
  // random source and reference model
  // ==========================================================================

  // galois lfsr on x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
    end
    return v;
  endfunction

  // {unit, length} of an opcode, grouped by the length rule of each unit
  function automatic logic [7:0] model_code(input logic [7:0] op);
    case (op)
      op_add, op_sub, op_and, op_or:      return {unit_alu, 4'd4};
      op_csr:                             return {unit_alu, 4'd5};
      op_perm:                            return {unit_alu, 4'd6};
      op_add5, op_or5, op_add2r, op_or2r: return {unit_alu, 4'd3};
      op_addui, op_orui:                  return {unit_alu, 4'd8};
      op_beq, op_bne, op_blt, op_bge:     return {unit_branch, 4'd3};
      op_blr:                             return {unit_branch, 4'd4};
      op_jmp, op_jsr:                     return {unit_branch, 4'd5};
      op_brk:                             return {unit_system, 4'd2};
      op_nop:                             return {unit_system, 4'd1};
      op_ldb, op_ldo, op_stb, op_sto:     return {unit_memory, 4'd4};
      op_ldos, op_stos:                   return {unit_memory, 4'd3};
      op_pma, op_pms:                     return {unit_post, 4'd4};
      op_fma, op_fms:                     return {unit_float, 4'd4};
      default:                            return {unit_default, 4'd4};
    endcase
  endfunction

  // n random instructions, then nops until the bytes fill whole words
  task automatic build_stream(input int n);
    logic [7:0]  op;
    logic [7:0]  code;
    logic [63:0] data;
    logic [7:0]  bytes [$];
    int          k;
    k = 0;
    while (k < n || bytes.size() % 4 != 0) begin
      if (k < n) begin
        op = take_bits(1) ? op_table[take_bits(5) % 31] : 8'(take_bits(8));
      end else begin
        op = op_nop;
      end
      code = model_code(op);
      data = 64'(op);
      for (int i = 1; i < int'(code[3:0]); i++) begin
        data[8*i +: 8] = 8'(take_bits(8));
      end
      for (int i = 0; i < int'(code[3:0]); i++) begin
        bytes.push_back(data[8*i +: 8]);
      end
      exp_data_q.push_back(data);
      exp_code_q.push_back(code);
      k++;
    end
    // lowest byte of each word goes first in the stream
    for (int i = 0; i < bytes.size(); i += 4) begin
      word_q.push_back({bytes[i+3], bytes[i+2], bytes[i+1], bytes[i]});
    end
  endtask

  // ==========================================================================
  // checks and reporting
  // ==========================================================================

  task automatic compare(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s %s: expected %h, actual %h",
               test_name, what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_error(input string what);
    $display("ERROR in %s: %s", test_name, what);
    errors++;
    test_errors++;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %s %s, %0d errors", test_name,
             (test_errors == 0) ? "ok" : "failed", test_errors);
    test_errors = 0;
  endtask

  // sampled half a cycle after the outputs change
  always @(negedge clk) begin
    if (!reset && instr_valid === 1'b1) begin
      if (stall_last) begin
        report_error("instruction emitted after a stalled cycle");
      end
      if (exp_data_q.size() == 0) begin
        report_error("instruction emitted with none expected");
      end else begin
        compare("instr_data", exp_data_q.pop_front(), instr_data);
        exp_code = exp_code_q.pop_front();
        compare("instr_len", 64'(exp_code[3:0]), 64'(instr_len));
        compare("instr_unit", 64'(exp_code[7:4]), 64'(instr_unit));
      end
    end
    // the stall level of this cycle decides the pulse seen at the next check
    stall_last = decode_stall;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit_cycles) begin
      $display("ERROR: run stopped at %0d cycles with %0d instructions still expected",
               cycles, exp_data_q.size());
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================

  // feeds words at random while there is room, stalls decode at random, and
  // holds decode stalled for the first hold cycles
  task automatic run_stream(input int hold, output logic ready_dropped);
    int n;
    n = 0;
    ready_dropped = 1'b0;
    while (word_q.size() != 0 || exp_data_q.size() != 0) begin
      @(posedge clk);
      #1;
      if (!fetch_ready) begin
        ready_dropped = 1'b1;
      end
      fetch_valid = 1'b0;
      if (word_q.size() != 0 && fetch_ready && take_bits(1) != 32'd0) begin
        fetch_valid = 1'b1;
        fetch_data  = word_q.pop_front();
      end
      decode_stall = (n < hold) || (take_bits(2) == 32'd3);
      n++;
    end
    fetch_valid  = 1'b0;
    decode_stall = 1'b0;
  endtask

  initial begin
    logic dropped;
    op_table = '{op_add, op_sub, op_and, op_or, op_csr, op_perm, op_add5, op_or5,
                 op_add2r, op_or2r, op_addui, op_orui, op_blr, op_jmp, op_jsr,
                 op_beq, op_bne, op_blt, op_bge, op_brk, op_nop, op_ldb, op_ldo,
                 op_ldos, op_stb, op_sto, op_stos, op_pma, op_pms, op_fma, op_fms};
    reset        = 1'b1;
    fetch_valid  = 1'b0;
    fetch_data   = '0;
    decode_stall = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;

    test_name = "reset_state";
    @(posedge clk);
    #1;
    compare("instr_valid", 64'd0, 64'(instr_valid));
    compare("fetch_ready", 64'd1, 64'(fetch_ready));
    finish_test();

    test_name = "random_stream";
    build_stream(stream_instrs);
    run_stream(0, dropped);
    finish_test();

    // the queue fills behind the hold until fetch_ready falls
    test_name = "long_stall";
    build_stream(stall_instrs);
    run_stream(stall_cycles, dropped);
    compare("fetch_ready_fell", 64'd1, 64'(dropped));
    // every byte has been consumed, so an idle stretch must stay free of pulses
    repeat (2 * max_instr_bytes) @(posedge clk);
    finish_test();

    // assertion failures from the bound checker count as errors too
    errors += uut.u_chk.failures;
    $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
             tests_run, tests_failed, errors, uut.u_chk.failures);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
source/rtf_pkg.sv
source/rtf_predecoder.sv
source/rtf_fetch_queue.sv
source/rtf_aligner.sv
source/rtf_ifetch_top.sv
test/rtf_ifetch_chk.sv
test/rtf_ifetch_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rtf_ifetch_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
